// File: Makefile
# Verilator build and run for the cache subsystem testbench
TOP := tb_cache_subsystem

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

# Fails unless the pass line shows up in the simulator output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

// File: cache_array.sv
// cache_array: direct-mapped tag, valid and data storage with combinational hit lookup
`timescale 1ns/1ps

module cache_array (
    input  logic              clk,          // System clock
    input  logic              arst_n,       // Async reset, clears valid bits
    input  cache_pkg::addr_t  addr,         // Lookup and write address
    input  cache_pkg::data_t  wdata,        // Word to store
    input  logic              write_data,   // Store wdata at addr
    input  cache_pkg::tag_t   tag_in,       // Tag to store for the indexed line
    input  logic              write_tag,    // Store tag_in and mark line valid
    output cache_pkg::data_t  rdata,        // Word at addr
    output logic              hit           // Line valid and tag matches
);

    ////////////////////
    // Address fields
    ////////////////////
    cache_pkg::tag_t    addr_tag;
    cache_pkg::index_t  addr_index;
    cache_pkg::offset_t addr_offset;

    assign {addr_tag, addr_index, addr_offset} = addr;  // tag | index | offset

    ////////////////////
    // Storage
    ////////////////////
    cache_pkg::data_t data_mem [cache_pkg::NUM_LINES][cache_pkg::WORDS_PER_LINE];
    cache_pkg::tag_t  tag_mem  [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid_bits;  // One per line

    // Data words
    always_ff @(posedge clk) begin
        if (write_data) begin
            data_mem[addr_index][addr_offset] <= wdata;
        end
    end

    // Tags
    always_ff @(posedge clk) begin
        if (write_tag) begin
            tag_mem[addr_index] <= tag_in;
        end
    end

    // Valid bits set together with the tag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;                    // Cold cache
        end else if (write_tag) begin
            valid_bits[addr_index] <= 1'b1;
        end
    end

    ////////////////////
    // Lookup
    ////////////////////
    // Hit needs both a valid line and a matching tag
    assign hit   = valid_bits[addr_index] && (tag_mem[addr_index] == addr_tag);
    assign rdata = data_mem[addr_index][addr_offset];  // Same-cycle read data

endmodule

// File: cache_fill_ctrl.sv
// cache_fill_ctrl: miss FSM that reads a whole block from main memory into the cache array
`timescale 1ns/1ps

module cache_fill_ctrl (
    input  logic                 clk,          // System clock
    input  logic                 arst_n,       // Async reset, active low
    input  logic                 miss,         // Core access missed while idle
    input  cache_pkg::addr_t     miss_addr,    // Core address of the missing access
    input  logic                 proceed,      // Memory grant for block reads
    input  cache_pkg::mem_rsp_t  rsp,          // Read responses from memory
    output logic                 fsm_busy,     // Stalls the core during a fill
    output cache_pkg::mem_req_t  req,          // Block read requests
    output cache_pkg::addr_t     fill_addr,    // Array address for fill and tag writes
    output cache_pkg::data_t     fill_data,    // Returned word for the array
    output logic                 write_data,   // Write fill_data into the array
    output cache_pkg::tag_t      tag_out,      // Tag of the block being filled
    output logic                 write_tag     // Write tag and set valid
);

    ////////////////////
    // State
    ////////////////////
    cache_pkg::fill_state_t state, state_nxt;

    cache_pkg::offset_t issue_cnt;    // Next word offset to request
    cache_pkg::offset_t rcv_cnt;      // Offset of the next word to come back
    cache_pkg::tag_t    base_tag;     // Block being filled
    cache_pkg::index_t  base_index;

    logic issue_go;     // Read request goes out this cycle
    logic last_issue;   // This request is the final word of the block
    logic rcv_go;       // Response word taken this cycle
    logic last_rcv;     // Final word of the block arrives

    // Issue only in FETCH and only with the grant
    assign issue_go   = (state == cache_pkg::FETCH) && proceed;
    assign last_issue = (issue_cnt == cache_pkg::offset_t'(cache_pkg::WORDS_PER_LINE - 1));

    // Responses may still arrive in FETCH while issuing is paused
    assign rcv_go   = rsp.valid &&
                      ((state == cache_pkg::FETCH) || (state == cache_pkg::DRAIN));
    assign last_rcv = rcv_go &&
                      (rcv_cnt == cache_pkg::offset_t'(cache_pkg::WORDS_PER_LINE - 1));

    ////////////////////
    // Next state
    ////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::IDLE: begin
                if (miss) begin
                    state_nxt = cache_pkg::FETCH;         // Busy from next cycle
                end
            end
            cache_pkg::FETCH: begin
                if (issue_go && last_issue) begin
                    state_nxt = cache_pkg::DRAIN;         // All reads sent
                end
            end
            cache_pkg::DRAIN: begin
                if (last_rcv) begin
                    state_nxt = cache_pkg::DONE;          // Whole block stored
                end
            end
            cache_pkg::DONE: begin
                state_nxt = cache_pkg::IDLE;              // Tag written this cycle
            end
            default: state_nxt = cache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cache_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    ////////////////////
    // Counters
    ////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_cnt <= '0;
            rcv_cnt   <= '0;
        end else if ((state == cache_pkg::IDLE) && miss) begin
            issue_cnt <= '0;                        // Block starts at offset 0
            rcv_cnt   <= '0;
        end else begin
            if (issue_go) issue_cnt <= issue_cnt + 1'b1;
            if (rcv_go)   rcv_cnt   <= rcv_cnt + 1'b1;   // Wraps to 0 after the last word
        end
    end

    // Block base captured on the miss
    always_ff @(posedge clk) begin
        if ((state == cache_pkg::IDLE) && miss) begin
            {base_tag, base_index} <= miss_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W];
        end
    end

    ////////////////////
    // Outputs
    ////////////////////
    assign fsm_busy = (state != cache_pkg::IDLE);

    // Read requests in offset order
    assign req.valid = issue_go;
    assign req.we    = 1'b0;
    assign req.addr  = {base_tag, base_index, issue_cnt};
    assign req.wdata = '0;

    // Array side
    assign fill_addr  = {base_tag, base_index, rcv_cnt};   // Offset 0 again in DONE
    assign fill_data  = rsp.data;
    assign write_data = rcv_go;
    assign tag_out    = base_tag;
    assign write_tag  = (state == cache_pkg::DONE);

endmodule

// File: cache_pkg.sv
// cache_pkg: shared geometry, memory timing and bus types for the L1 cache subsystem
package cache_pkg;

    ////////////////////
    // Geometry
    ////////////////////
    localparam int ADDR_W         = 16;  // Word address width
    localparam int DATA_W         = 16;  // Data word width
    localparam int TAG_W          = 8;   // Upper address bits kept per line
    localparam int INDEX_W        = 5;   // Selects one of the lines
    localparam int OFFSET_W       = 3;   // Word inside a line
    localparam int NUM_LINES      = 32;
    localparam int WORDS_PER_LINE = 8;

    // Main memory behaviour
    localparam int MEM_LATENCY = 2;                          // Read request to response
    localparam logic [DATA_W-1:0] MEM_INIT_KEY = 16'h5a3c;   // Contents are addr ^ key

    ////////////////////
    // Types
    ////////////////////
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [OFFSET_W-1:0] offset_t;

    // Request toward main memory
    typedef struct packed {
        logic  valid;   // Memory accepts every valid request
        logic  we;      // 1 = write, 0 = read
        addr_t addr;
        data_t wdata;
    } mem_req_t;

    // Read response from main memory
    typedef struct packed {
        logic  valid;
        data_t data;
    } mem_rsp_t;

    // Block fill sequence
    typedef enum logic [1:0] {IDLE, FETCH, DRAIN, DONE} fill_state_t;

endpackage

// File: cache_subsystem_top.sv
// cache_subsystem_top: L1 cache with its fill controller and the main memory model
`timescale 1ns/1ps

module cache_subsystem_top (
    input  logic              clk,        // System clock
    input  logic              arst_n,     // Async reset, active low
    input  logic              enable,     // Core access request
    input  logic              wr,         // Core write
    input  cache_pkg::addr_t  addr,       // Core word address
    input  cache_pkg::data_t  wdata,      // Core write data
    input  logic              proceed,    // Memory grant
    output cache_pkg::data_t  data_out,   // Read data
    output logic              hit,        // Cache hit
    output logic              fsm_busy    // Core stall
);

    ////////////////////
    // Memory bus
    ////////////////////
    cache_pkg::mem_req_t mem_req;   // Cache to memory
    cache_pkg::mem_rsp_t mem_rsp;   // Memory to cache

    memory_system i_memory_system (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .proceed  (proceed),
        .mem_rsp  (mem_rsp),
        .mem_req  (mem_req),
        .data_out (data_out),
        .hit      (hit),
        .fsm_busy (fsm_busy)
    );

    main_memory i_main_memory (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (mem_req),
        .rsp    (mem_rsp)
    );

endmodule

// File: flist.f
cache_pkg.sv
cache_array.sv
cache_fill_ctrl.sv
memory_system.sv
main_memory.sv
cache_subsystem_top.sv
tb_cache_subsystem.sv

// File: main_memory.sv
// main_memory: word-addressed backing store with a fixed-latency pipelined read path
`timescale 1ns/1ps

module main_memory (
    input  logic                 clk,      // System clock
    input  logic                 arst_n,   // Async reset, clears response valid
    input  cache_pkg::mem_req_t  req,      // Read or write request
    output cache_pkg::mem_rsp_t  rsp       // Read response
);

    localparam int DEPTH = 2 ** cache_pkg::ADDR_W;   // Full 64K word space

    ////////////////////
    // Storage
    ////////////////////
    cache_pkg::data_t mem [DEPTH];

    // Known pattern at time zero
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = cache_pkg::data_t'(i) ^ cache_pkg::MEM_INIT_KEY;
        end
    end

    // Write lands on the accepting edge
    always @(posedge clk) begin
        if (req.valid && req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

    ////////////////////
    // Read pipeline
    ////////////////////
    logic [cache_pkg::MEM_LATENCY-1:0] pipe_valid;
    cache_pkg::data_t                  pipe_data [cache_pkg::MEM_LATENCY];
    logic                              rd_accept;

    assign rd_accept = req.valid && !req.we;   // No throttling here

    // Valid bits shift toward the output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pipe_valid <= '0;
        end else begin
            pipe_valid[0] <= rd_accept;
            for (int s = 1; s < cache_pkg::MEM_LATENCY; s++) begin
                pipe_valid[s] <= pipe_valid[s-1];
            end
        end
    end

    // Data travels beside its valid bit
    always_ff @(posedge clk) begin
        pipe_data[0] <= mem[req.addr];   // Sampled at accept
        for (int s = 1; s < cache_pkg::MEM_LATENCY; s++) begin
            pipe_data[s] <= pipe_data[s-1];
        end
    end

    // Last stage is the response
    assign rsp.valid = pipe_valid[cache_pkg::MEM_LATENCY-1];
    assign rsp.data  = pipe_data[cache_pkg::MEM_LATENCY-1];

endmodule

// File: memory_system.sv
// memory_system: joins cache array and fill controller and merges write-through traffic
`timescale 1ns/1ps

module memory_system (
    input  logic                 clk,        // System clock
    input  logic                 arst_n,     // Async reset, active low
    input  logic                 enable,     // Core access request
    input  logic                 wr,         // Core write
    input  cache_pkg::addr_t     addr,       // Core word address
    input  cache_pkg::data_t     wdata,      // Core write data
    input  logic                 proceed,    // Memory grant for fills
    input  cache_pkg::mem_rsp_t  mem_rsp,    // Read responses from memory
    output cache_pkg::mem_req_t  mem_req,    // Fill reads or write-through
    output cache_pkg::data_t     data_out,   // Read data to the core
    output logic                 hit,        // Array hit
    output logic                 fsm_busy    // Fill in progress
);

    ////////////////////
    // Internal signals
    ////////////////////
    cache_pkg::addr_t    arr_addr;        // Array address after the mux
    cache_pkg::data_t    arr_wdata;
    logic                arr_write_data;
    cache_pkg::tag_t     fill_tag;
    logic                fill_write_tag;
    cache_pkg::addr_t    fill_addr;       // Controller side of the array port
    cache_pkg::data_t    fill_data;
    logic                fill_write_data;
    cache_pkg::mem_req_t fill_req;
    logic                miss;
    logic                core_wr_hit;     // Write hit from the core this cycle

    // Core owns the array port while idle
    assign arr_addr       = fsm_busy ? fill_addr : addr;
    assign arr_wdata      = fsm_busy ? fill_data : wdata;
    assign core_wr_hit    = enable && wr && hit && !fsm_busy;
    assign arr_write_data = fsm_busy ? fill_write_data : core_wr_hit;
    assign miss           = enable && !hit && !fsm_busy;   // Read or write miss

    cache_array i_cache_array (
        .clk        (clk),
        .arst_n     (arst_n),
        .addr       (arr_addr),
        .wdata      (arr_wdata),
        .write_data (arr_write_data),
        .tag_in     (fill_tag),
        .write_tag  (fill_write_tag),
        .rdata      (data_out),
        .hit        (hit)
    );

    cache_fill_ctrl i_cache_fill_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .miss       (miss),
        .miss_addr  (addr),
        .proceed    (proceed),
        .rsp        (mem_rsp),
        .fsm_busy   (fsm_busy),
        .req        (fill_req),
        .fill_addr  (fill_addr),
        .fill_data  (fill_data),
        .write_data (fill_write_data),
        .tag_out    (fill_tag),
        .write_tag  (fill_write_tag)
    );

    // Fill reads while busy, else write-through of a core write hit
    always_comb begin
        if (fsm_busy) begin
            mem_req = fill_req;
        end else begin
            mem_req.valid = core_wr_hit;
            mem_req.we    = 1'b1;
            mem_req.addr  = addr;
            mem_req.wdata = wdata;
        end
    end

endmodule

// File: tb_cache_subsystem.sv
// tb_cache_subsystem: self-checking testbench that runs core traffic against a shadow memory
`timescale 1ns/1ps

module tb_cache_subsystem;

    localparam int TIMEOUT_CYCLES = 20000;  // About 4x the full run with every access missing

    logic             clk;
    logic             arst_n;
    logic             enable;
    logic             wr;
    cache_pkg::addr_t addr;
    cache_pkg::data_t wdata;
    logic             proceed;
    cache_pkg::data_t data_out;
    logic             hit;
    logic             fsm_busy;

    cache_pkg::data_t shadow [cache_pkg::addr_t];  // Only words written so far
    logic [31:0] rnd_state;                        // Traffic generator
    logic [31:0] bp_state;                         // Grant generator
    logic        bp_mode;                          // Random proceed while set
    int          errors;                           // Failed procedural checks
    int          prop_errors;                      // Failed protocol properties
    int          checks;
    int          tests;
    int          tests_failed;
    int          test_err0;                        // Error count at test start
    int          cycles = 0;
    string       test_name;

    cache_subsystem_top uut (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .wr       (wr),
        .addr     (addr),
        .wdata    (wdata),
        .proceed  (proceed),
        .data_out (data_out),
        .hit      (hit),
        .fsm_busy (fsm_busy)
    );

    ////////////////////
    // Clock and run limit
    ////////////////////
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    ////////////////////
    // Protocol properties
    ////////////////////
    // Fill starts only from a core miss
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(fsm_busy) |-> $past(enable && !hit)) else begin
        $display("Fill started without a core miss at cycle %0d", cycles);
        prop_errors++;
    end

    // Block reads go out only with the grant
    assert property (@(posedge clk) disable iff (!arst_n)
        (uut.mem_req.valid && !uut.mem_req.we) |-> proceed) else begin
        $display("Memory read issued while proceed was low at cycle %0d", cycles);
        prop_errors++;
    end

    // Every core write hit goes through to memory in the same cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        (enable && wr && hit && !fsm_busy) |->
        (uut.mem_req.valid && uut.mem_req.we &&
         uut.mem_req.addr == addr && uut.mem_req.wdata == wdata)) else begin
        $display("Write hit to %h had no matching write-through request", $sampled(addr));
        prop_errors++;
    end

    // Held address hits as soon as the fill ends, so the tag is in place
    assert property (@(posedge clk) disable iff (!arst_n)
        $fell(fsm_busy) |-> (enable && hit)) else begin
        $display("Fill ended without a hit on the held address at cycle %0d", cycles);
        prop_errors++;
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Memory image rule: written value, else address XOR key
    function automatic cache_pkg::data_t expected_word(input cache_pkg::addr_t a);
        if (shadow.exists(a)) return shadow[a];
        return a ^ cache_pkg::MEM_INIT_KEY;
    endfunction

    task automatic check_word(input string name, input cache_pkg::data_t got,
                              input cache_pkg::data_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Grant for the coming cycle
    task automatic update_proceed();
        if (bp_mode) begin
            bp_state = lcg_step(bp_state);
            proceed  = bp_state[31];
        end else begin
            proceed = 1'b1;
        end
    endtask

    // One core access held until completion; outputs sampled at the completing edge
    task automatic access(input logic is_wr, input cache_pkg::addr_t a,
                          input cache_pkg::data_t d, output cache_pkg::data_t rd,
                          output logic first_hit, output logic saw_busy);
        logic done;
        saw_busy = 1'b0;
        @(negedge clk);
        update_proceed();
        enable = 1'b1;
        wr     = is_wr;
        addr   = a;
        wdata  = d;
        @(posedge clk);
        first_hit = hit && !fsm_busy;
        done      = first_hit;
        while (!done) begin
            @(negedge clk);
            update_proceed();
            @(posedge clk);
            if (fsm_busy) saw_busy = 1'b1;
            done = hit && !fsm_busy;   // Global cycle limit guards this wait
        end
        rd = data_out;
        if (is_wr) shadow[a] = d;      // Write lands at this edge
        @(negedge clk);
        enable = 1'b0;
        wr     = 1'b0;
    endtask

    task automatic read_word(input cache_pkg::addr_t a, output logic first_hit,
                             output logic saw_busy);
        cache_pkg::data_t rd;
        access(1'b0, a, '0, rd, first_hit, saw_busy);
        check_word($sformatf("data_out[%h]", a), rd, expected_word(a));
    endtask

    task automatic write_word(input cache_pkg::addr_t a, input cache_pkg::data_t d,
                              output logic first_hit);
        cache_pkg::data_t rd;
        logic             sb;
        access(1'b1, a, d, rd, first_hit, sb);
    endtask

    // All 8 words of a block must hit at once with correct data
    task automatic check_block(input cache_pkg::addr_t base);
        cache_pkg::addr_t a;
        logic             fh;
        logic             sb;
        for (int o = 0; o < cache_pkg::WORDS_PER_LINE; o++) begin
            a = {base[15:3], cache_pkg::offset_t'(o)};
            read_word(a, fh, sb);
            check_bit($sformatf("hit[%h]", a), fh, 1'b1);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors + prop_errors;
        tests++;
    endtask

    task automatic end_test();
        int n;
        n = errors + prop_errors - test_err0;
        if (n == 0) begin
            $display("test %0d %s: passed", tests, test_name);
        end else begin
            $display("test %0d %s: failed with %0d errors", tests, test_name, n);
            tests_failed++;
        end
    endtask

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        logic [31:0]      r;
        cache_pkg::addr_t a;
        logic             fh;
        logic             sb;
        enable       = 1'b0;
        wr           = 1'b0;
        addr         = '0;
        wdata        = '0;
        proceed      = 1'b1;
        arst_n       = 1'b0;
        bp_mode      = 1'b0;
        rnd_state    = 32'hfbec;
        bp_state     = lcg_step(32'hfbec);   // Own stream for the grant
        errors       = 0;
        prop_errors  = 0;
        checks       = 0;
        tests        = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("reset state");
        @(posedge clk);
        check_bit("fsm_busy", fsm_busy, 1'b0);
        read_word(16'h1234, fh, sb);
        check_bit("hit", fh, 1'b0);            // Cold cache
        check_bit("fsm_busy", sb, 1'b1);
        end_test();

        start_test("cold read miss");
        read_word(16'h2a45, fh, sb);
        check_bit("hit", fh, 1'b0);
        check_block(16'h2a40);
        end_test();

        start_test("write hit");
        write_word(16'h2a43, 16'hbeef, fh);
        check_bit("hit", fh, 1'b1);
        read_word(16'h2a43, fh, sb);
        check_bit("hit", fh, 1'b1);
        read_word(16'h7745, fh, sb);           // Same index, other tag
        check_bit("hit", fh, 1'b0);
        read_word(16'h2a43, fh, sb);           // Refetched from memory
        check_bit("hit", fh, 1'b0);
        end_test();

        start_test("write miss");
        write_word(16'h9c15, 16'h1357, fh);
        check_bit("hit", fh, 1'b0);
        check_block(16'h9c10);                 // Written word plus neighbours
        end_test();

        start_test("back-pressure");
        bp_mode = 1'b1;
        read_word(16'h4b83, fh, sb);
        check_bit("hit", fh, 1'b0);
        check_block(16'h4b80);
        read_word(16'h0fcf, fh, sb);
        check_bit("hit", fh, 1'b0);
        check_block(16'h0fc8);
        write_word(16'h6e2d, 16'hc0de, fh);
        check_bit("hit", fh, 1'b0);
        check_block(16'h6e28);
        bp_mode = 1'b0;
        end_test();

        start_test("random traffic");
        for (int i = 0; i < 200; i++) begin
            rnd_state = lcg_step(rnd_state);
            r         = rnd_state;
            bp_mode   = (i >= 100);            // Second half with random grant
            // 4 tags over 8 lines keeps conflicts frequent
            a = {6'b101101, r[9:8], 2'b01, r[4:2], r[7:5]};
            if (r[12]) begin
                write_word(a, r[31:16], fh);
            end else begin
                read_word(a, fh, sb);
            end
        end
        bp_mode = 1'b0;
        end_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests, tests_failed, checks, errors + prop_errors);
        if (errors + prop_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
